// File: br_arb_pkg.sv
package br_arb_pkg;

  // --------------------
  // Arbitration sizing
  // --------------------

  // Number of requesters sharing the command port
  localparam int num_requesters = 4;

  // Width of an index that names one requester
  localparam int req_idx_width = 2;

  // --------------------
  // Queue sizing
  // --------------------

  // Entries held by each per-requester queue
  localparam int queue_depth = 4;

  // Read and write pointers wrap naturally since the depth is a power of two
  localparam int queue_ptr_width = 2;

endpackage

// File: br_arb_rr.sv
`timescale 1ns/1ps

// Round-robin arbiter with zero latency from request to grant
module br_arb_rr #(
  // Must be at least 2
  parameter int num_requesters = 2
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      enable,
  input  logic [num_requesters-1:0] request,
  output logic [num_requesters-1:0] grant
);

  // Requests above the last winner, which take priority before the wrap
  logic [num_requesters-1:0] priority_mask;
  logic [num_requesters-1:0] request_high;

  // Candidate grants from the two encoders
  logic [num_requesters-1:0] grant_high;
  logic [num_requesters-1:0] grant_low;
  logic [num_requesters-1:0] grant_pick;

  // Index of the winner this cycle and of the previous winner
  logic [$clog2(num_requesters)-1:0] grant_idx;
  logic [$clog2(num_requesters)-1:0] last_grant;

  // --------------------
  // Masked request
  // --------------------

  // Only indices strictly above the last winner stay in the high set
  always_comb begin
    priority_mask = '0;
    for (int i = 0; i < num_requesters; i++) begin
      if (i > int'(last_grant)) begin
        priority_mask[i] = 1'b1;
      end
    end
  end

  assign request_high = request & priority_mask;

  // --------------------
  // Encoders
  // --------------------

  br_enc_priority_encoder #(
    .num_requesters(num_requesters)
  ) enc_high (
    .in (request_high),
    .out(grant_high)
  );

  // The unmasked copy only matters after the wrap, when the high set is empty
  br_enc_priority_encoder #(
    .num_requesters(num_requesters)
  ) enc_low (
    .in (request),
    .out(grant_low)
  );

  assign grant_pick = (|request_high) ? grant_high : grant_low;

  // Nothing is granted while enable is low
  assign grant = {num_requesters{enable}} & grant_pick;

  // One-hot winner turned back into an index for the priority register
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < num_requesters; i++) begin
      if (grant_pick[i]) begin
        grant_idx = $bits(grant_idx)'(i);
      end
    end
  end

  // --------------------
  // Priority state
  // --------------------

  // Starts at the top index so that index 0 leads out of reset
  // and the priority holds still while enable is low
  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= $bits(last_grant)'(num_requesters - 1);
    end else if (|request && enable) begin
      last_grant <= grant_idx;
    end
  end

  // --------------------
  // Checks
  // --------------------

  grant_onehot0_a: assert property (@(posedge clk) disable iff (reset)
    $onehot0(grant));

  // A winner must still be asking in the same cycle
  grant_implies_request_a: assert property (@(posedge clk) disable iff (reset)
    (grant & request) == grant);

  grant_only_when_enabled_a: assert property (@(posedge clk) disable iff (reset)
    |grant |-> enable);

endmodule

// File: br_cmd_arb_top.sv
`timescale 1ns/1ps

// Four command queues merged onto one port by round-robin arbitration
module br_cmd_arb_top
  import br_arb_pkg::*;
  import br_cmd_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      enable,
  input  logic [num_requesters-1:0] in_valid,
  input  logic [cmd_width-1:0]      in_cmd [num_requesters],
  output logic                      out_valid,
  output logic [req_idx_width-1:0]  out_source,
  output logic                      out_write,
  output logic [addr_width-1:0]     out_addr,
  output logic [wdata_width-1:0]    out_wdata,
  output logic [tag_width-1:0]      out_tag,
  output logic [num_requesters-1:0] overflow
);

  // Queue status doubles as the request vector
  logic [num_requesters-1:0] not_empty;
  logic [num_requesters-1:0] grant;
  logic [cmd_width-1:0]      head [num_requesters];

  // --------------------
  // Queues
  // --------------------

  // Each granted queue pops its head at the same edge that registers the output
  for (genvar i = 0; i < num_requesters; i++) begin : g_queue
    br_cmd_queue queue (
      .clk      (clk),
      .reset    (reset),
      .push     (in_valid[i]),
      .push_cmd (in_cmd[i]),
      .pop      (grant[i]),
      .not_empty(not_empty[i]),
      .head     (head[i]),
      .overflow (overflow[i])
    );
  end

  // --------------------
  // Arbiter and output
  // --------------------

  br_arb_rr #(
    .num_requesters(num_requesters)
  ) arb (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .request(not_empty),
    .grant  (grant)
  );

  br_cmd_select select (
    .clk       (clk),
    .reset     (reset),
    .grant     (grant),
    .head      (head),
    .out_valid (out_valid),
    .out_source(out_source),
    .out_write (out_write),
    .out_addr  (out_addr),
    .out_wdata (out_wdata),
    .out_tag   (out_tag)
  );

endmodule

// File: br_cmd_pkg.sv
package br_cmd_pkg;

  // --------------------
  // Command word layout
  // --------------------

  // Full command word as pushed by a requester
  localparam int cmd_width = 32;

  // Field widths shared by both views of the word
  localparam int addr_width = 7;
  localparam int wdata_width = 24;
  localparam int tag_width = 8;

  // Opcode values carried in bit 31
  localparam logic op_read = 1'b0;
  localparam logic op_write = 1'b1;

  // Write view with opcode and address followed by write data in the low 24 bits
  typedef struct packed {
    logic                   op;
    logic [addr_width-1:0]  addr;
    logic [wdata_width-1:0] wdata;
  } wr_cmd_t;

  // Read view with opcode, address and a returned tag above 16 unused bits
  typedef struct packed {
    logic                                      op;
    logic [addr_width-1:0]                     addr;
    logic [tag_width-1:0]                      tag;
    logic [cmd_width-2-addr_width-tag_width:0] rsvd;
  } rd_cmd_t;

  // The same 32 bits read either way depending on the opcode
  typedef union packed {
    wr_cmd_t wr;
    rd_cmd_t rd;
  } cmd_word_t;

endpackage

// File: br_cmd_queue.sv
`timescale 1ns/1ps

// Small FIFO of command words for one requester
module br_cmd_queue
  import br_arb_pkg::*;
  import br_cmd_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 push,
  input  logic [cmd_width-1:0] push_cmd,
  input  logic                 pop,
  output logic                 not_empty,
  output logic [cmd_width-1:0] head,
  output logic                 overflow
);

  // Storage holds payload only, its contents are qualified by count
  logic [cmd_width-1:0] mem [queue_depth];

  logic [queue_ptr_width-1:0] rd_ptr;
  logic [queue_ptr_width-1:0] wr_ptr;

  // One bit wider than the pointers so that a full queue can be told from an empty one
  logic [queue_ptr_width:0] count;

  logic full;
  logic push_ok;

  // --------------------
  // Status
  // --------------------

  assign full = (int'(count) == queue_depth);
  assign not_empty = (count != '0);

  // A push into a full queue is lost, even if a pop frees a slot at the same edge
  assign push_ok = push && !full;

  assign head = mem[rd_ptr];

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sticky until the next reset so the loss can be read out later
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (push && full) begin
      overflow <= 1'b1;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // The arbiter only grants queues that report a word, so an empty pop is an arbiter fault
  pop_not_empty_a: assert property (@(posedge clk) disable iff (reset)
    pop |-> not_empty);

  count_in_range_a: assert property (@(posedge clk) disable iff (reset)
    int'(count) <= queue_depth);

endmodule

// File: br_cmd_select.sv
`timescale 1ns/1ps

// Picks the granted head, decodes it and presents it for one cycle
module br_cmd_select
  import br_arb_pkg::*;
  import br_cmd_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [num_requesters-1:0] grant,
  input  logic [cmd_width-1:0]      head [num_requesters],
  output logic                      out_valid,
  output logic [req_idx_width-1:0]  out_source,
  output logic                      out_write,
  output logic [addr_width-1:0]     out_addr,
  output logic [wdata_width-1:0]    out_wdata,
  output logic [tag_width-1:0]      out_tag
);

  // Granted word, read through either view
  cmd_word_t sel_word;
  logic [req_idx_width-1:0] sel_source;

  // --------------------
  // Mux and encode
  // --------------------

  // The grant is one-hot, so the OR over the gated heads is a plain mux
  always_comb begin
    sel_word = '0;
    sel_source = '0;
    for (int i = 0; i < num_requesters; i++) begin
      if (grant[i]) begin
        sel_word = sel_word | head[i];
        sel_source = req_idx_width'(i);
      end
    end
  end

  // --------------------
  // Output register
  // --------------------

  // Strobe is high for exactly one cycle per grant
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= |grant;
    end
  end

  // Fields load only with a grant and are meaningful only with out_valid
  always_ff @(posedge clk) begin
    if (|grant) begin
      out_source <= sel_source;
      out_write <= (sel_word.wr.op == op_write);
      out_addr <= sel_word.wr.addr;
      // The field that the opcode does not use is driven to zero
      out_wdata <= (sel_word.wr.op == op_write) ? sel_word.wr.wdata : '0;
      out_tag <= (sel_word.rd.op == op_read) ? sel_word.rd.tag : '0;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Two bits at once would OR two heads together
  grant_onehot0_a: assert property (@(posedge clk) disable iff (reset)
    $onehot0(grant));

endmodule

// File: br_enc_priority_encoder.sv
`timescale 1ns/1ps

// Finds the lowest-index set bit of a request vector and returns it one-hot
module br_enc_priority_encoder #(
  // Must be at least 2
  parameter int num_requesters = 2
) (
  input  logic [num_requesters-1:0] in,
  output logic [num_requesters-1:0] out
);

  // Set once the first request has been taken during the scan
  logic found;

  // --------------------
  // Scan
  // --------------------

  always_comb begin
    out = '0;
    found = 1'b0;
    // Index 0 wins over every higher index
    for (int i = 0; i < num_requesters; i++) begin
      if (in[i] && !found) begin
        out[i] = 1'b1;
        found = 1'b1;
      end
    end
    // At most one bit may survive the scan, and none when nothing was asked for
    assert ($onehot0(out))
    else $error("priority encoder output is not one-hot: %b", out);
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the arbiter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_br_cmd_arb -Mdir "$obj" -o sim_tb -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$obj/sim_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$log"; then
  exit 1
fi
if ! grep -q "Test passed" "$log"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// File: tb.f
+incdir+.
br_arb_pkg.sv
br_cmd_pkg.sv
br_enc_priority_encoder.sv
br_arb_rr.sv
br_cmd_queue.sv
br_cmd_select.sv
br_cmd_arb_top.sv
tb_br_cmd_arb.sv

// File: tb_br_cmd_ref.svh
`ifndef TB_BR_CMD_REF_SVH
`define TB_BR_CMD_REF_SVH

// --------------------
// Reference model
// --------------------

// One expected output beat, with the cycle on which out_valid must be seen
typedef struct packed {
  logic [req_idx_width-1:0] source;
  logic                     write;
  logic [addr_width-1:0]    addr;
  logic [wdata_width-1:0]   wdata;
  logic [tag_width-1:0]     tag;
  logic [31:0]              due;
} exp_out_t;

// Model queues mirror the per-requester FIFOs word for word
logic [cmd_width-1:0]      model_q [num_requesters][$];
logic [req_idx_width-1:0]  model_last;
logic [num_requesters-1:0] model_ovf;
exp_out_t                  expect_q [$];

// Writes carry 24 data bits, reads carry an 8-bit tag; the other field reads as zero
function automatic exp_out_t decode_cmd(input logic [cmd_width-1:0] word,
                                        input logic [req_idx_width-1:0] src);
  cmd_word_t w;
  exp_out_t e;
  w = word;
  e = '0;
  e.source = src;
  e.write = (w.wr.op == op_write);
  e.addr = w.wr.addr;
  if (e.write) begin
    e.wdata = w.wr.wdata;
  end else begin
    e.tag = w.rd.tag;
  end
  return e;
endfunction

// First non-empty queue after the last winner, wrapping around; -1 when all are empty
function automatic int pick_rr();
  int idx;
  int winner;
  winner = -1;
  for (int k = 1; k <= num_requesters; k++) begin
    idx = (int'(model_last) + k) % num_requesters;
    if (winner < 0 && model_q[idx].size() != 0) begin
      winner = idx;
    end
  end
  return winner;
endfunction

task automatic model_reset();
  for (int i = 0; i < num_requesters; i++) begin
    model_q[i].delete();
  end
  // Index 0 leads after reset
  model_last = req_idx_width'(num_requesters - 1);
  model_ovf = '0;
  expect_q.delete();
endtask

// Advances the model by one clock edge, using the inputs the DUT samples at that edge
task automatic model_step();
  int winner;
  exp_out_t e;
  winner = -1;
  if (enable) begin
    winner = pick_rr();
  end
  if (winner >= 0) begin
    e = decode_cmd(model_q[winner][0], req_idx_width'(winner));
    // The output register shows the word one edge later
    e.due = cycle_count + 1;
    expect_q.push_back(e);
  end
  // Fullness is judged before this edge's pop, so a pop never makes room for a push
  for (int i = 0; i < num_requesters; i++) begin
    if (in_valid[i]) begin
      if (model_q[i].size() == queue_depth) begin
        model_ovf[i] = 1'b1;
      end else begin
        model_q[i].push_back(in_cmd[i]);
      end
    end
  end
  if (winner >= 0) begin
    void'(model_q[winner].pop_front());
    model_last = req_idx_width'(winner);
  end
endtask

// True while any word is still queued or any output is still due
function automatic logic model_busy();
  logic busy;
  busy = (expect_q.size() != 0);
  for (int i = 0; i < num_requesters; i++) begin
    if (model_q[i].size() != 0) begin
      busy = 1'b1;
    end
  end
  return busy;
endfunction

`endif

// File: tb_br_cmd_arb.sv
`timescale 1ns/1ps

// Testbench for the four-way round-robin command arbiter
module tb_br_cmd_arb
  import br_arb_pkg::*;
  import br_cmd_pkg::*;
();

  // Stimulus length of each test in cycles bounds the run
  localparam int t1_cycles = 24;
  localparam int t2_cycles = 4;
  localparam int t3_cycles = 200;
  localparam int t4_cycles = 12;
  localparam int t5_cycles = 6;
  localparam int t6_cycles = 16;
  localparam int reset_cycles = 3;
  localparam int num_tests = 6;
  localparam int stim_cycles = t1_cycles + t2_cycles + t3_cycles + t4_cycles
                             + t5_cycles + t6_cycles + num_tests * reset_cycles;
  localparam int cycle_limit = 2 * stim_cycles + 100;

  logic                      clk;
  logic                      reset;
  logic                      enable;
  logic [num_requesters-1:0] in_valid;
  logic [cmd_width-1:0]      in_cmd [num_requesters];
  logic                      out_valid;
  logic [req_idx_width-1:0]  out_source;
  logic                      out_write;
  logic [addr_width-1:0]     out_addr;
  logic [wdata_width-1:0]    out_wdata;
  logic [tag_width-1:0]      out_tag;
  logic [num_requesters-1:0] overflow;

  // Words prepared for the next drive cycle
  logic [cmd_width-1:0] stage_cmd [num_requesters];
  int unsigned cycle_count = 0;
  string test_name;
  int test_errors;
  int tests_passed;
  int tests_failed;

`include "tb_br_cmd_ref.svh"

  br_cmd_arb_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .in_valid  (in_valid),
    .in_cmd    (in_cmd),
    .out_valid (out_valid),
    .out_source(out_source),
    .out_write (out_write),
    .out_addr  (out_addr),
    .out_wdata (out_wdata),
    .out_tag   (out_tag),
    .overflow  (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Comparison
  // --------------------

  // All fields of one output beat as readable text
  function automatic string beat_text(input logic [req_idx_width-1:0] src,
                                      input logic wr,
                                      input logic [addr_width-1:0] addr,
                                      input logic [wdata_width-1:0] wdata,
                                      input logic [tag_width-1:0] tag);
    return $sformatf("src %0d wr %0b addr %h wdata %h tag %h", src, wr, addr, wdata, tag);
  endfunction

  task automatic check_outputs();
    exp_out_t e;
    assert (overflow === model_ovf)
    else begin
      $display("mismatch %s overflow expected %b actual %b", test_name, model_ovf, overflow);
      test_errors++;
    end
    if (out_valid === 1'b1) begin
      assert (expect_q.size() != 0)
      else begin
        $display("%s: out_valid rose while no output was expected", test_name);
        test_errors++;
      end
      if (expect_q.size() != 0) begin
        e = expect_q.pop_front();
        assert (e.due == cycle_count)
        else begin
          $display("mismatch %s out_valid cycle expected %0d actual %0d",
                   test_name, e.due, cycle_count);
          test_errors++;
        end
        assert ({out_source, out_write, out_addr, out_wdata, out_tag} ===
                {e.source, e.write, e.addr, e.wdata, e.tag})
        else begin
          $display("mismatch %s expected %s actual %s", test_name,
                   beat_text(e.source, e.write, e.addr, e.wdata, e.tag),
                   beat_text(out_source, out_write, out_addr, out_wdata, out_tag));
          test_errors++;
        end
      end
    end else begin
      assert (out_valid === 1'b0)
      else begin
        $display("%s: out_valid is unknown", test_name);
        test_errors++;
      end
      // A due beat that did not show up is dropped so later beats still line up
      assert (expect_q.size() == 0 || expect_q[0].due > cycle_count)
      else begin
        $display("%s: output from source %0d never came", test_name, expect_q[0].source);
        test_errors++;
        void'(expect_q.pop_front());
      end
    end
  endtask

  // Model and DUT both see the inputs as they were just before the edge
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end else if (reset) begin
      model_reset();
    end else begin
      check_outputs();
      model_step();
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  task automatic drive_cycle(input logic [num_requesters-1:0] valid, input logic en);
    @(posedge clk);
    in_valid <= valid;
    in_cmd <= stage_cmd;
    enable <= en;
  endtask

  task automatic fill_random();
    for (int i = 0; i < num_requesters; i++) begin
      stage_cmd[i] = $urandom();
    end
  endtask

  // Reset is seen high at two edges
  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    in_valid <= '0;
    enable <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  // Stops pushing and waits on the falling edge until every queued word is out
  task automatic wait_drain();
    drive_cycle('0, 1'b1);
    @(negedge clk);
    while (model_busy()) begin
      @(negedge clk);
    end
  endtask

  task automatic check_overflow(input logic [num_requesters-1:0] expected);
    assert (overflow === expected)
    else begin
      $display("mismatch %s overflow expected %b actual %b", test_name, expected, overflow);
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    apply_reset();
    test_errors = 0;
  endtask

  task automatic end_test();
    assert (expect_q.size() == 0)
    else begin
      $display("%s: %0d outputs still pending at the end", test_name, expect_q.size());
      test_errors++;
    end
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: ok", test_name);
    end else begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", test_name, test_errors);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    logic [num_requesters-1:0] valid;
    reset = 1'b1;
    enable = 1'b0;
    in_valid = '0;
    in_cmd = '{default: '0};
    stage_cmd = '{default: '0};
    tests_passed = 0;
    tests_failed = 0;
    test_errors = 0;
    void'($urandom(57589));

    // Requester 2 alone, with gaps of zero to two cycles between pushes
    begin_test("single_requester");
    for (int k = 0; k < 8; k++) begin
      fill_random();
      drive_cycle(4'b0100, 1'b1);
      repeat (k % 3) drive_cycle('0, 1'b1);
    end
    wait_drain();
    end_test();

    // All four queues filled while disabled and then released at once
    begin_test("full_rotation");
    repeat (t2_cycles) begin
      fill_random();
      drive_cycle('1, 1'b0);
    end
    wait_drain();
    end_test();

    begin_test("random_sparse");
    for (int k = 0; k < t3_cycles; k++) begin
      fill_random();
      for (int i = 0; i < num_requesters; i++) begin
        valid[i] = (($urandom() % 8) == 0);
      end
      drive_cycle(valid, ($urandom() % 16) != 0);
    end
    wait_drain();
    end_test();

    // Requester 1 wins first, so the held words must drain starting at 2
    begin_test("enable_hold");
    fill_random();
    drive_cycle(4'b0010, 1'b1);
    wait_drain();
    repeat (2) begin
      fill_random();
      drive_cycle('1, 1'b0);
    end
    repeat (8) drive_cycle('0, 1'b0);
    wait_drain();
    end_test();

    // Five pushes into a depth of four lose the last one
    begin_test("overflow");
    repeat (5) begin
      fill_random();
      drive_cycle(4'b1000, 1'b0);
    end
    drive_cycle('0, 1'b0);
    @(negedge clk);
    check_overflow(4'b1000);
    wait_drain();
    check_overflow(4'b1000);
    end_test();

    // Writes on even steps and reads on odd steps, with all-ones corner words first
    begin_test("decode_fields");
    for (int k = 0; k < t6_cycles; k++) begin
      fill_random();
      stage_cmd[k % num_requesters][cmd_width-1] = (k % 2 == 0) ? op_write : op_read;
      if (k == 0) begin
        stage_cmd[0] = 32'hffff_ffff;
      end
      if (k == 1) begin
        stage_cmd[1] = 32'h7fff_ffff;
      end
      drive_cycle(num_requesters'(1 << (k % num_requesters)), 1'b1);
    end
    wait_drain();
    end_test();

    $display("summary: %0d tests ok, %0d tests failing", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
